// ==== all.f ====
+incdir+source
source/norm_pkg.sv
source/norm_links_if.sv
source/group_stats.sv
source/group_buffer.sv
source/group_normalizer.sv
source/group_norm_top.sv
bench/group_norm_tb.sv

// ==== bench/group_norm_tb.sv ====
// Checks the normalizer against an integer model, stimulus drives 1 ns after each rising edge
`timescale 1ns/100ps
`include "norm_settings.svh"

module group_norm_tb;

    localparam int lanes = `NORM_LANES;
    localparam int group_beats = `NORM_GROUP_BEATS;
    localparam int n_samples = lanes * group_beats;
    localparam int in_w = lanes * `NORM_IN_WIDTH;
    localparam int out_w = lanes * `NORM_OUT_WIDTH;
    localparam int beat_timeout = 1000;
    localparam int drain_timeout = 5000;

    logic             clk;
    logic             rst;
    logic [in_w-1:0]  in_data;
    logic             in_valid;
    logic             in_ready;
    logic [out_w-1:0] out_data;
    logic             out_valid;
    logic             out_ready;

    logic [31:0]      data_state;
    logic [31:0]      ready_state;
    logic             stall_mode;
    int               grp [n_samples];
    logic [out_w-1:0] exp_q [$];
    string            name_q [$];
    int               in_count;
    int               out_count;
    logic             stalled;
    logic [out_w-1:0] stalled_data;
    string            stalled_name;

    group_norm_top UUT (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Division rounding toward minus infinity, divisor positive
    function automatic int floor_div(input int a, input int b);
        int q;
        q = a / b;
        if ((a % b != 0) && (a < 0)) begin
            q = q - 1;
        end
        return q;
    endfunction

    function automatic int int_sqrt(input int v);
        int r;
        r = 0;
        while ((r + 1) * (r + 1) <= v) begin
            r = r + 1;
        end
        return r;
    endfunction

    function automatic int saturate(input int v);
        int hi;
        int lo;
        hi = (1 << (`NORM_OUT_WIDTH - 1)) - 1;
        lo = -(1 << (`NORM_OUT_WIDTH - 1));
        if (v > hi) begin
            return hi;
        end else if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    // Expected beats of the group now held in grp
    task automatic model_group(input string name);
        int               sum;
        int               sumsq;
        int               mean;
        int               variance;
        int               sd;
        int               inv;
        int               val;
        logic [out_w-1:0] beat;
        sum   = 0;
        sumsq = 0;
        for (int k = 0; k < n_samples; k++) begin
            sum   = sum + grp[k];
            sumsq = sumsq + grp[k] * grp[k];
        end
        mean     = floor_div(sum, n_samples);
        variance = floor_div(sumsq, n_samples) - mean * mean;
        if (variance < 0) begin
            variance = 0;
        end
        sd = int_sqrt(variance);
        if (sd == 0) begin
            inv = (1 << `NORM_INV_WIDTH) - 1;
        end else begin
            inv = (1 << `NORM_INV_FRAC) / sd;
        end
        for (int b = 0; b < group_beats; b++) begin
            for (int i = 0; i < lanes; i++) begin
                val = floor_div((grp[b * lanes + i] - mean) * inv,
                                1 << (`NORM_INV_FRAC - `NORM_OUT_FRAC));
                val = saturate(val);
                beat[i * `NORM_OUT_WIDTH +: `NORM_OUT_WIDTH] = val[`NORM_OUT_WIDTH-1:0];
            end
            exp_q.push_back(beat);
            name_q.push_back(name);
        end
    endtask

    task automatic send_beat(input logic [in_w-1:0] data);
        int waited;
        waited   = 0;
        in_data  = data;
        in_valid = 1'b1;
        // in_ready depends on DUT state only, so it is settled here
        while (!in_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > beat_timeout) begin
                abort_run("an input beat was not accepted before the timeout");
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in_count++;
    endtask

    task automatic send_group(input string name);
        logic [in_w-1:0] data;
        model_group(name);
        for (int b = 0; b < group_beats; b++) begin
            for (int i = 0; i < lanes; i++) begin
                data[i * `NORM_IN_WIDTH +: `NORM_IN_WIDTH] = grp[b * lanes + i][`NORM_IN_WIDTH-1:0];
            end
            send_beat(data);
        end
    endtask

    task automatic fill_constant(input int v);
        for (int k = 0; k < n_samples; k++) begin
            grp[k] = v;
        end
    endtask

    task automatic fill_random();
        for (int k = 0; k < n_samples; k++) begin
            data_state = lcg_step(data_state);
            grp[k]     = $signed(data_state[23:16]);
        end
    endtask

    task automatic fill_outlier(input int base, input int outlier, input int pos);
        fill_constant(base);
        grp[pos] = outlier;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > drain_timeout) begin
                abort_run("expected output beats were still pending after the drain timeout");
            end
        end
    endtask

    // Random out_ready while stalling is enabled
    initial begin
        ready_state = 32'd60768;
        forever begin
            @(posedge clk);
            #1;
            if (stall_mode) begin
                ready_state = lcg_step(ready_state);
                out_ready   = ready_state[30];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // Outputs are sampled at the falling edge where they are stable
    always @(negedge clk) begin
        if (rst) begin
            assert (out_valid === 1'b0) else abort_run("out_valid was high during reset");
            stalled = 1'b0;
        end else begin
            if (stalled) begin
                assert (out_valid === 1'b1) else abort_run("out_valid dropped while stalled");
                assert (out_data === stalled_data) else abort_run($sformatf(
                    "FAIL %s hold: expected %h, actual %h", stalled_name, stalled_data, out_data));
            end
            if (out_valid) begin
                assert (exp_q.size() > 0) else abort_run("an output beat appeared with none expected");
            end
            if (out_valid && out_ready) begin
                assert (out_data === exp_q[0]) else abort_run($sformatf(
                    "FAIL %s: expected %h, actual %h", name_q[0], exp_q[0], out_data));
                void'(exp_q.pop_front());
                void'(name_q.pop_front());
                out_count++;
            end
            stalled      = out_valid && !out_ready;
            stalled_data = out_data;
            stalled_name = (exp_q.size() > 0) ? name_q[0] : "idle";
        end
    end

    initial begin
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        out_ready  = 1'b1;
        stall_mode = 1'b0;
        data_state = 32'd60768;
        in_count   = 0;
        out_count  = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // Idle after reset
        repeat (10) begin
            @(posedge clk);
            #1;
            assert (out_valid === 1'b0) else abort_run("out_valid rose before any input was sent");
        end

        fill_constant(37);
        send_group("constant group");
        repeat (4) begin
            fill_random();
            send_group("random groups");
        end
        fill_outlier(10, 100, 13);
        send_group("saturation high");
        fill_outlier(10, -100, 22);
        send_group("saturation low");
        wait_drain();

        stall_mode = 1'b1;
        repeat (6) begin
            fill_random();
            send_group("back-pressure");
        end
        wait_drain();
        stall_mode = 1'b0;
        repeat (20) @(posedge clk);

        if (out_count != in_count || exp_q.size() != 0) begin
            abort_run($sformatf("FAIL beat count: expected %0d, actual %0d", in_count, out_count));
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it, failing when the log reports a failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module group_norm_tb -o group_norm_sim

# The simulator exits non-zero on $fatal, the log decides the result
./obj_dir/group_norm_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// ==== source/group_buffer.sv ====
// Depth must be a power of two and at least one group, and the read side is combinational
`timescale 1ns/100ps
`include "norm_settings.svh"

module group_buffer (
    input  logic              clk,
    input  logic              rst,
    input  norm_pkg::sample_t lanes [`NORM_LANES],
    input  logic              in_valid,
    output logic              in_ready,
    beat_if.source            beats
);
    import norm_pkg::*;

    localparam int ptr_w = $clog2(`NORM_BUFFER_DEPTH);

    sample_t        mem [`NORM_BUFFER_DEPTH][`NORM_LANES];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             push;
    logic             pop;

    assign push = in_valid && in_ready;
    assign pop  = beats.valid && beats.ready;

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= lanes;
        end
    end

    assign in_ready    = (count != (ptr_w + 1)'(`NORM_BUFFER_DEPTH));
    assign beats.valid = (count != '0);
    assign beats.lanes = mem[rd_ptr];

endmodule

// ==== source/group_norm_top.sv ====
// A beat enters the statistics path and the buffer together, so both must be ready for it
`timescale 1ns/100ps
`include "norm_settings.svh"

module group_norm_top (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [`NORM_LANES*`NORM_IN_WIDTH-1:0]    in_data,
    input  logic                                     in_valid,
    output logic                                     in_ready,
    output logic [`NORM_LANES*`NORM_OUT_WIDTH-1:0]   out_data,
    output logic                                     out_valid,
    input  logic                                     out_ready
);
    import norm_pkg::*;

    sample_t in_lanes [`NORM_LANES];
    out_t    out_lanes [`NORM_LANES];
    logic    stats_in_ready;
    logic    buffer_in_ready;

    beat_if  beat_link ();
    stats_if stats_link ();

    // Lane 0 sits in the low bits
    for (genvar i = 0; i < `NORM_LANES; i++) begin : g_lanes
        assign in_lanes[i] = in_data[i*`NORM_IN_WIDTH +: `NORM_IN_WIDTH];
        assign out_data[i*`NORM_OUT_WIDTH +: `NORM_OUT_WIDTH] = out_lanes[i];
    end

    assign in_ready = stats_in_ready && buffer_in_ready;

    group_stats u_stats (
        .clk      (clk),
        .rst      (rst),
        .lanes    (in_lanes),
        .in_valid (in_valid && buffer_in_ready),
        .in_ready (stats_in_ready),
        .stats    (stats_link)
    );

    group_buffer u_buffer (
        .clk      (clk),
        .rst      (rst),
        .lanes    (in_lanes),
        .in_valid (in_valid && stats_in_ready),
        .in_ready (buffer_in_ready),
        .beats    (beat_link)
    );

    group_normalizer u_normalizer (
        .clk       (clk),
        .rst       (rst),
        .stats     (stats_link),
        .beats     (beat_link),
        .out_lanes (out_lanes),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// ==== source/group_normalizer.sv ====
// Output is floor-shifted and saturated, and one group's statistics serve exactly one group of beats
`timescale 1ns/100ps
`include "norm_settings.svh"

module group_normalizer (
    input  logic           clk,
    input  logic           rst,
    stats_if.sink          stats,
    beat_if.sink           beats,
    output norm_pkg::out_t out_lanes [`NORM_LANES],
    output logic           out_valid,
    input  logic           out_ready
);
    import norm_pkg::*;

    localparam int prod_w = `NORM_IN_WIDTH + `NORM_INV_WIDTH + 2;
    localparam int shift_bits = `NORM_INV_FRAC - `NORM_OUT_FRAC;

    logic        held;
    sample_t     mean_q;
    inv_t        inv_q;
    beat_count_t beat_cnt;
    logic        take;
    out_t        norm_lanes [`NORM_LANES];
    out_t        skid_lanes [`NORM_LANES];
    logic        skid_valid;

    function automatic out_t normalize(input sample_t x, input sample_t mean, input inv_t inv);
        diff_t                          diff;
        logic signed [prod_w-1:0]       prod;
        logic signed [prod_w-1:0]       scaled;
        logic [prod_w-`NORM_OUT_WIDTH:0] top;
        diff   = diff_t'(x) - diff_t'(mean);
        prod   = diff * $signed({1'b0, inv});
        scaled = prod >>> shift_bits;
        top    = scaled[prod_w-1:`NORM_OUT_WIDTH-1];
        // Fits when all bits above the output sign agree with it
        if (&top || ~|top) begin
            return out_t'(scaled);
        end else if (scaled[prod_w-1]) begin
            return {1'b1, {(`NORM_OUT_WIDTH-1){1'b0}}};
        end else begin
            return {1'b0, {(`NORM_OUT_WIDTH-1){1'b1}}};
        end
    endfunction

    // Beats are taken only with statistics in hand and room in the output stage
    assign take         = held && beats.valid && !skid_valid;
    assign beats.ready  = held && !skid_valid;
    assign stats.ready  = !held;

    always_comb begin
        for (int i = 0; i < `NORM_LANES; i++) begin
            norm_lanes[i] = normalize(beats.lanes[i], mean_q, inv_q);
        end
    end

    // Statistics stay until the group's last beat is consumed
    always_ff @(posedge clk) begin
        if (rst) begin
            held     <= 1'b0;
            beat_cnt <= '0;
        end else if (stats.valid && stats.ready) begin
            held <= 1'b1;
        end else if (take) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == beat_count_t'(`NORM_GROUP_BEATS - 1)) begin
                held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stats.valid && stats.ready) begin
            mean_q <= stats.mean;
            inv_q  <= stats.inv_std;
        end
    end

    // Output register with one skid slot
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!out_valid || out_ready) begin
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= take;
            end
        end else if (take) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!out_valid || out_ready) begin
            if (skid_valid) begin
                out_lanes <= skid_lanes;
            end else if (take) begin
                out_lanes <= norm_lanes;
            end
        end else if (take) begin
            skid_lanes <= norm_lanes;
        end
    end

endmodule

// ==== source/group_stats.sv ====
// Group size must be a power of two and beats are refused while a group's statistics are pending
`timescale 1ns/100ps
`include "norm_settings.svh"

module group_stats (
    input  logic              clk,
    input  logic              rst,
    input  norm_pkg::sample_t lanes [`NORM_LANES],
    input  logic              in_valid,
    output logic              in_ready,
    stats_if.source           stats
);
    import norm_pkg::*;

    localparam int rad_w = 2 * `NORM_IN_WIDTH;
    localparam int rem_w = `NORM_IN_WIDTH + 3;
    localparam int step_w = $clog2(`NORM_INV_WIDTH);

    stats_state_t      state;
    beat_count_t       beat_cnt;
    logic [step_w-1:0] step_cnt;
    logic              accept;
    logic              last_beat;

    sum_t    sum_acc;
    sum_t    beat_sum;
    sum_t    sum_next;
    sumsq_t  sq_acc;
    sumsq_t  beat_sq;
    sumsq_t  sq_next;
    sumsq_t  mean_sq;
    sumsq_t  msq;
    sample_t mean_next;
    sample_t mean_q;
    var_t    variance;

    // Square root datapath
    logic [rad_w-1:0] rad;
    logic [rem_w-1:0] rem;
    logic [rem_w-1:0] rem_shift;
    logic [rem_w-1:0] trial;
    root_t            root;

    // Divider datapath, the quotient shifts in as the dividend shifts out
    logic [`NORM_IN_WIDTH:0] div_shift;
    root_t                   div_rem;
    inv_t                    div_q;

    function automatic sumsq_t square(input sample_t x);
        logic [rad_w-1:0] p;
        p = x * x;
        return sumsq_t'(p);
    endfunction

    // Adder stage over the lanes of one beat
    always_comb begin
        beat_sum = '0;
        beat_sq  = '0;
        for (int i = 0; i < `NORM_LANES; i++) begin
            beat_sum = beat_sum + sum_t'(lanes[i]);
            beat_sq  = beat_sq + square(lanes[i]);
        end
    end

    assign accept    = in_valid && in_ready;
    assign last_beat = accept && (beat_cnt == beat_count_t'(`NORM_GROUP_BEATS - 1));
    assign sum_next  = sum_acc + beat_sum;
    assign sq_next   = sq_acc + beat_sq;

    // Floor division by N is an arithmetic shift
    assign mean_next = sample_t'(sum_next >>> `NORM_LOG2_N);
    assign msq       = sq_next >> `NORM_LOG2_N;
    assign mean_sq   = square(mean_next);
    assign variance  = (msq > mean_sq) ? var_t'(msq - mean_sq) : '0;

    // Two radicand bits per root step
    assign rem_shift = {rem[rem_w-3:0], rad[rad_w-1 -: 2]};
    assign trial     = {1'b0, root, 2'b01};
    assign div_shift = {div_rem, div_q[`NORM_INV_WIDTH-1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ACCUM;
            beat_cnt <= '0;
            step_cnt <= '0;
            sum_acc  <= '0;
            sq_acc   <= '0;
        end else begin
            case (state)
                ACCUM: begin
                    if (accept) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        sum_acc  <= sum_next;
                        sq_acc   <= sq_next;
                    end
                    if (last_beat) begin
                        sum_acc  <= '0;
                        sq_acc   <= '0;
                        step_cnt <= '0;
                        state    <= ROOT;
                    end
                end
                ROOT: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == step_w'(`NORM_IN_WIDTH - 1)) begin
                        step_cnt <= '0;
                        state    <= DIVIDE;
                    end
                end
                DIVIDE: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (step_cnt == step_w'(`NORM_INV_WIDTH - 1)) begin
                        step_cnt <= '0;
                        state    <= HOLD;
                    end
                end
                HOLD: begin
                    if (stats.ready) begin
                        state <= ACCUM;
                    end
                end
                default: state <= ACCUM;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            ACCUM: begin
                if (last_beat) begin
                    mean_q <= mean_next;
                    rad    <= rad_w'(variance);
                    root   <= '0;
                    rem    <= '0;
                end
            end
            ROOT: begin
                rad <= rad << 2;
                if (rem_shift >= trial) begin
                    rem  <= rem_shift - trial;
                    root <= {root[`NORM_IN_WIDTH-2:0], 1'b1};
                end else begin
                    rem  <= rem_shift;
                    root <= {root[`NORM_IN_WIDTH-2:0], 1'b0};
                end
                // Dividend is 2**NORM_INV_FRAC
                div_rem <= '0;
                div_q   <= inv_t'(1) << `NORM_INV_FRAC;
            end
            DIVIDE: begin
                // A zero root passes every compare, so the quotient ends all ones
                if (div_shift >= {1'b0, root}) begin
                    div_rem <= root_t'(div_shift - {1'b0, root});
                    div_q   <= {div_q[`NORM_INV_WIDTH-2:0], 1'b1};
                end else begin
                    div_rem <= root_t'(div_shift);
                    div_q   <= {div_q[`NORM_INV_WIDTH-2:0], 1'b0};
                end
            end
            default: begin
            end
        endcase
    end

    assign in_ready      = (state == ACCUM);
    assign stats.valid   = (state == HOLD);
    assign stats.mean    = mean_q;
    assign stats.inv_std = div_q;

endmodule

// ==== source/norm_links_if.sv ====
// Both links use valid/ready and the source holds its payload until the transfer
`timescale 1ns/100ps
`include "norm_settings.svh"

// One beat of raw samples, buffer to normalizer
interface beat_if;
    import norm_pkg::*;

    sample_t lanes [`NORM_LANES];
    logic    valid;
    logic    ready;

    modport source (output lanes, output valid, input ready);
    modport sink (input lanes, input valid, output ready);
endinterface

// One group's statistics, engine to normalizer
interface stats_if;
    import norm_pkg::*;

    sample_t mean;
    inv_t    inv_std;
    logic    valid;
    logic    ready;

    modport source (output mean, output inv_std, output valid, input ready);
    modport sink (input mean, input inv_std, input valid, output ready);
endinterface

// ==== source/norm_pkg.sv ====
// Type widths follow the settings header and assume the sums never exceed 2**NORM_LOG2_N samples
`include "norm_settings.svh"

package norm_pkg;

    // Stream samples
    typedef logic signed [`NORM_IN_WIDTH-1:0] sample_t;
    typedef logic signed [`NORM_IN_WIDTH:0] diff_t;
    typedef logic signed [`NORM_OUT_WIDTH-1:0] out_t;

    // Group accumulators
    typedef logic signed [`NORM_IN_WIDTH+`NORM_LOG2_N-1:0] sum_t;
    typedef logic [2*`NORM_IN_WIDTH+`NORM_LOG2_N-2:0] sumsq_t;

    // Statistics results
    typedef logic [2*`NORM_IN_WIDTH-2:0] var_t;
    typedef logic [`NORM_IN_WIDTH-1:0] root_t;
    typedef logic [`NORM_INV_WIDTH-1:0] inv_t;

    // Beat index inside one group
    typedef logic [$clog2(`NORM_GROUP_BEATS)-1:0] beat_count_t;

    // Statistics engine phases
    typedef enum logic [1:0] {
        ACCUM,
        ROOT,
        DIVIDE,
        HOLD
    } stats_state_t;

endpackage

// ==== source/norm_settings.svh ====
// Sizes are fixed at build time, and NORM_LANES * NORM_GROUP_BEATS must equal 2**NORM_LOG2_N
`ifndef NORM_SETTINGS_SVH
`define NORM_SETTINGS_SVH

// Stream shape
`define NORM_LANES 4
`define NORM_GROUP_BEATS 8
`define NORM_LOG2_N 5

// Sample widths, inputs are plain signed integers
`define NORM_IN_WIDTH 8
`define NORM_OUT_WIDTH 8
`define NORM_OUT_FRAC 5

// Inverse deviation is unsigned with NORM_INV_FRAC fraction bits
`define NORM_INV_FRAC 12
`define NORM_INV_WIDTH 13

// Raw beat storage, power of two, two whole groups
`define NORM_BUFFER_DEPTH 16

`endif
